// ==== all.f ====
i2c_proto_pkg.sv
i2c_timing_pkg.sv
i2c_bit_if.sv
i2c_shift_if.sv
i2c_bit_timer.sv
i2c_byte_shifter.sv
i2c_txn_ctrl.sv
i2c_master_top.sv
i2c_slave_model.sv
tb_i2c_master.sv

// ==== tb_i2c_master.sv ====
`timescale 1ns/100ps
module tb_i2c_master;

    localparam int TIMEOUT_CYCLES = 200000;

    logic        i_clk;
    logic        reset_n;
    logic        req_trans;
    logic [6:0]  addr;
    logic        rw;
    logic [15:0] sub_addr;
    logic        sub_len;
    logic [7:0]  byte_len;
    logic [7:0]  data_write;
    logic [7:0]  data_out;
    logic        rd_valid;
    logic        wr_req;
    logic        busy;
    logic        nack;
    logic        stretch_en;
    logic        sub16;
    wire         scl;
    wire         sda;
    logic [31:0] rng;             // LCG state
    logic [7:0]  wr_buf [0:7];    // Bytes handed to the DUT
    logic [7:0]  rd_q [$];        // Bytes seen on rd_valid_o
    int          wr_cnt;
    int          check_count;
    int          err_count;
    int          timeout_count;

    pullup (scl);
    pullup (sda);

    i2c_master_top dut0 (
        .i_clk        (i_clk),
        .reset_n      (reset_n),
        .req_trans_i  (req_trans),
        .addr_i       (addr),
        .rw_i         (rw),
        .sub_addr_i   (sub_addr),
        .sub_len_i    (sub_len),
        .byte_len_i   (byte_len),
        .data_write_i (data_write),
        .data_out_o   (data_out),
        .rd_valid_o   (rd_valid),
        .wr_req_o     (wr_req),
        .busy_o       (busy),
        .nack_o       (nack),
        .scl_o        (scl),
        .sda_o        (sda)
    );

    i2c_slave_model #(.DEV_ADDR(7'h50)) u_slave (
        .scl_o        (scl),
        .sda_o        (sda),
        .stretch_en_i (stretch_en),
        .sub16_i      (sub16)
    );

    always #10 i_clk = ~i_clk;

    // Outputs are stable at the falling edge
    always @(negedge i_clk) begin
        if (wr_req)
            wr_cnt++;
        if (rd_valid)
            rd_q.push_back(data_out);
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout at %0t ns while waiting for %s", $time, what);
    endtask

    task automatic wait_busy(input logic level, input string what);
        int n;
        n = 0;
        while (busy !== level && n < TIMEOUT_CYCLES) begin
            @(negedge i_clk);
            n++;
        end
        if (busy !== level)
            report_timeout(what);
    endtask

    task automatic start_txn(input logic [6:0] a, input logic r, input logic [15:0] sub,
                             input logic s16, input int len);
        @(negedge i_clk);
        addr      = a;
        rw        = r;
        sub_addr  = sub;
        sub_len   = s16;
        byte_len  = len[7:0];
        req_trans = 1'b1;
        wait_busy(1'b1, "busy_o to rise");
        req_trans = 1'b0;  // Accepted once busy_o is high
    endtask

    task automatic i2c_write(input logic [6:0] a, input logic [15:0] sub, input logic s16,
                             input int len);
        int n;
        wr_cnt = 0;
        start_txn(a, 1'b0, sub, s16, len);
        for (int i = 0; i < len; i++) begin
            n = 0;
            do begin
                @(negedge i_clk);
                n++;
            end while (!wr_req && busy && n < TIMEOUT_CYCLES);
            if (!wr_req && busy)
                report_timeout("wr_req_o");
            data_write = wr_buf[i];  // Held until the next request
        end
        wait_busy(1'b0, "busy_o to fall after write");
    endtask

    task automatic i2c_read(input logic [6:0] a, input logic [15:0] sub, input logic s16,
                            input int len);
        rd_q.delete();
        start_txn(a, 1'b1, sub, s16, len);
        wait_busy(1'b0, "busy_o to fall after read");
    endtask

    task automatic test_reset_state();
        check_eq(busy, 0, "busy_o after reset");
        check_eq(nack, 0, "nack_o after reset");
        check_eq(wr_req, 0, "wr_req_o after reset");
        check_eq(rd_valid, 0, "rd_valid_o after reset");
        check_eq(scl === 1'b1, 1, "SCL released after reset");
        check_eq(sda === 1'b1, 1, "SDA released after reset");
    endtask

    task automatic test_write_read(input logic [15:0] sub, input logic s16,
                                   input logic stretch, input int len);
        stretch_en = stretch;
        sub16      = s16;  // Slave expects the same sub-address width
        for (int i = 0; i < len; i++) begin
            rng       = lcg_step(rng);
            wr_buf[i] = rng[31:24];
        end
        i2c_write(7'h50, sub, s16, len);
        check_eq(wr_cnt, len, "wr_req_o pulse count");
        check_eq(nack, 0, "nack_o after write");
        // Bytes must land at the requested sub-address
        for (int i = 0; i < len; i++)
            check_eq(u_slave.mem[sub + 16'(i)], wr_buf[i], $sformatf("slave byte %0d", i));
        i2c_read(7'h50, sub, s16, len);
        check_eq(rd_q.size(), len, "rd_valid_o pulse count");
        for (int i = 0; i < rd_q.size() && i < len; i++)
            check_eq(rd_q[i], wr_buf[i], $sformatf("read byte %0d", i));
        check_eq(nack, 0, "nack_o after read");
        stretch_en = 1'b0;
    endtask

    task automatic test_nack_abort();
        i2c_read(7'h23, 16'h0010, 1'b0, 2);  // No slave answers here
        check_eq(nack, 1, "nack_o on missing slave");
        check_eq(rd_q.size(), 0, "rd_valid_o pulses on abort");
        check_eq(scl === 1'b1, 1, "SCL high after abort");
        check_eq(sda === 1'b1, 1, "SDA high after abort");
        i2c_read(7'h50, 16'h0080, 1'b0, 1);  // First byte of the stretch test
        check_eq(nack, 0, "nack_o cleared by next request");
        check_eq(rd_q.size(), 1, "rd_valid_o pulses after abort");
        if (rd_q.size() > 0)
            check_eq(rd_q[0], wr_buf[0], "read byte after abort");
    endtask

    initial begin
        i_clk         = 1'b0;
        reset_n       = 1'b0;
        req_trans     = 1'b0;
        addr          = '0;
        rw            = 1'b0;
        sub_addr      = '0;
        sub_len       = 1'b0;
        byte_len      = '0;
        data_write    = '0;
        stretch_en    = 1'b0;
        sub16         = 1'b0;
        wr_cnt        = 0;
        check_count   = 0;
        err_count     = 0;
        timeout_count = 0;
        rng           = 32'he335_58bf;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        reset_n = 1'b1;
        test_reset_state();
        test_write_read(16'h0012, 1'b0, 1'b0, 4);  // 8-bit sub-address
        test_write_read(16'h1A3C, 1'b1, 1'b0, 4);  // 16-bit sub-address
        test_write_read(16'h0080, 1'b0, 1'b1, 3);  // Slave stretches SCL
        test_nack_abort();
        $display("Checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== i2c_slave_model.sv ====
`timescale 1ns/100ps
module i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR = 7'h50  // 7-bit bus address
) (
    inout  wire  scl_o,         // Open drain SCL
    inout  wire  sda_o,         // Open drain SDA
    input  logic stretch_en_i,  // Hold SCL low after each falling edge
    input  logic sub16_i        // 1 expects a 16-bit sub-address
);

    typedef enum logic [2:0] {S_IDLE, S_ADDR, S_SUB_HI, S_SUB_LO, S_WRITE, S_READ} slave_state_t;

    logic [7:0]   mem [0:65535];  // 64 KiB register space
    slave_state_t state;
    logic [3:0]   bit_cnt;        // 0..7 data, 8 ACK slot
    logic [7:0]   shreg;          // RX byte, or TX byte in read
    logic [15:0]  ptr;            // Auto-incrementing memory pointer
    logic         rw;
    logic         fresh;          // Next falling edge is the one after START
    logic         master_ack;
    logic         sda_pull;
    logic         scl_pull;

    assign scl_o = scl_pull ? 1'b0 : 1'bz;
    assign sda_o = sda_pull ? 1'b0 : 1'bz;

    initial begin
        state      = S_IDLE;
        bit_cnt    = '0;
        shreg      = '0;
        ptr        = '0;
        rw         = 1'b0;
        fresh      = 1'b0;
        master_ack = 1'b0;
        sda_pull   = 1'b0;
        scl_pull   = 1'b0;
        for (int i = 0; i < 65536; i++)
            mem[i] = i[15:8] ^ i[7:0] ^ 8'hA5;  // Pattern over the whole address
    end

    always @(negedge sda_o) begin
        if (scl_o === 1'b1) begin  // START or repeated START
            state   = S_ADDR;
            bit_cnt = '0;
            fresh   = 1'b1;
        end
    end

    always @(posedge sda_o) begin
        if (scl_o === 1'b1) begin  // STOP
            state    = S_IDLE;
            sda_pull = 1'b0;
        end
    end

    // Stretch each low phase past the master's own half period
    always @(negedge scl_o) begin
        if (stretch_en_i && state != S_IDLE) begin
            scl_pull = 1'b1;
            #4000;
            scl_pull = 1'b0;
        end
    end

    always @(posedge scl_o) begin
        if (state == S_READ && bit_cnt == 4'd8)
            master_ack = (sda_o === 1'b0);  // Low means ACK from master
        else if (state != S_IDLE && state != S_READ && bit_cnt < 4'd8)
            shreg = {shreg[6:0], sda_o === 1'b1};
    end

    always @(negedge scl_o) begin
        #100;  // Hold after SCL falls
        if (fresh) begin
            fresh = 1'b0;
        end else if (state != S_IDLE && bit_cnt < 4'd7) begin
            bit_cnt = bit_cnt + 1'b1;
            if (state == S_READ)
                sda_pull = !shreg[7 - bit_cnt];
        end else if (state != S_IDLE && bit_cnt == 4'd7) begin
            bit_cnt  = 4'd8;
            sda_pull = (state != S_READ);  // ACK received bytes
            case (state)
                S_ADDR: begin
                    rw = shreg[0];
                    if (shreg[7:1] != DEV_ADDR) begin
                        sda_pull = 1'b0;  // Not ours, stay silent
                        state    = S_IDLE;
                    end
                end
                S_SUB_HI: ptr[15:8] = shreg;
                S_SUB_LO: ptr = sub16_i ? {ptr[15:8], shreg} : {8'h00, shreg};
                S_WRITE: begin
                    mem[ptr] = shreg;
                    ptr      = ptr + 1'b1;
                end
                default: ;
            endcase
        end else if (state != S_IDLE) begin
            bit_cnt  = '0;
            sda_pull = 1'b0;
            if (state == S_ADDR && !rw)
                state = sub16_i ? S_SUB_HI : S_SUB_LO;
            else if (state == S_SUB_HI)
                state = S_SUB_LO;
            else if (state == S_SUB_LO)
                state = S_WRITE;
            else if (state == S_READ && !master_ack)
                state = S_IDLE;  // NACK ends the read
            if ((state == S_ADDR && rw) || state == S_READ) begin
                state    = S_READ;
                shreg    = mem[ptr];
                ptr      = ptr + 1'b1;
                sda_pull = !shreg[7];  // MSB first
            end
        end
    end

endmodule

// ==== i2c_master_top.sv ====
`timescale 1ns/100ps
module i2c_master_top (
    input  logic                                 i_clk,
    input  logic                                 reset_n,
    input  logic                                 req_trans_i,
    input  logic [6:0]                           addr_i,
    input  logic                                 rw_i,
    input  logic [i2c_proto_pkg::SUB_ADDR_W-1:0] sub_addr_i,
    input  logic                                 sub_len_i,
    input  logic [i2c_proto_pkg::LEN_W-1:0]      byte_len_i,
    input  logic [i2c_proto_pkg::BYTE_W-1:0]     data_write_i,
    output logic [i2c_proto_pkg::BYTE_W-1:0]     data_out_o,
    output logic                                 rd_valid_o,
    output logic                                 wr_req_o,
    output logic                                 busy_o,
    output logic                                 nack_o,
    inout  wire                                  scl_o,  // Open drain, external pullup
    inout  wire                                  sda_o   // Open drain, external pullup
);

    i2c_bit_if   bit_bus ();  // Timer strobes and SCL state
    i2c_shift_if sh_bus ();   // Controller to shifter ops

    i2c_bit_timer u_bit_timer (
        .i_clk      (i_clk),
        .reset_n    (reset_n),
        .scl_line_i (scl_o),
        .bits       (bit_bus.timer)
    );

    i2c_byte_shifter u_byte_shifter (
        .i_clk      (i_clk),
        .reset_n    (reset_n),
        .sda_line_i (sda_o),
        .bits       (bit_bus.user),
        .sh         (sh_bus.shifter)
    );

    i2c_txn_ctrl u_txn_ctrl (
        .i_clk        (i_clk),
        .reset_n      (reset_n),
        .req_trans_i  (req_trans_i),
        .addr_i       (addr_i),
        .rw_i         (rw_i),
        .sub_addr_i   (sub_addr_i),
        .sub_len_i    (sub_len_i),
        .byte_len_i   (byte_len_i),
        .data_write_i (data_write_i),
        .data_out_o   (data_out_o),
        .rd_valid_o   (rd_valid_o),
        .wr_req_o     (wr_req_o),
        .busy_o       (busy_o),
        .nack_o       (nack_o),
        .bits         (bit_bus.ctrl),
        .sh           (sh_bus.ctrl)
    );

    assign scl_o = bit_bus.scl_pull ? 1'b0 : 1'bz;  // Drive low or float
    assign sda_o = sh_bus.sda_pull  ? 1'b0 : 1'bz;

endmodule

// ==== i2c_txn_ctrl.sv ====
`timescale 1ns/100ps
module i2c_txn_ctrl (
    input  logic                                 i_clk,
    input  logic                                 reset_n,
    input  logic                                 req_trans_i,   // Accepted in IDLE only
    input  logic [6:0]                           addr_i,        // 7-bit slave address
    input  logic                                 rw_i,          // 1 reads
    input  logic [i2c_proto_pkg::SUB_ADDR_W-1:0] sub_addr_i,
    input  logic                                 sub_len_i,     // 1 uses 16-bit sub-address
    input  logic [i2c_proto_pkg::LEN_W-1:0]      byte_len_i,    // 1 to 255
    input  logic [i2c_proto_pkg::BYTE_W-1:0]     data_write_i,
    output logic [i2c_proto_pkg::BYTE_W-1:0]     data_out_o,
    output logic                                 rd_valid_o,
    output logic                                 wr_req_o,
    output logic                                 busy_o,
    output logic                                 nack_o,
    i2c_bit_if.ctrl                              bits,
    i2c_shift_if.ctrl                            sh
);

    i2c_proto_pkg::txn_state_t               state;
    logic [1:0]                              step;      // Issue and wait or fetch sequence
    logic [i2c_proto_pkg::LEN_W-1:0]         byte_cnt;  // Bytes finished
    logic [6:0]                              addr_q;
    logic                                    rw_q;
    logic [i2c_proto_pkg::SUB_ADDR_W-1:0]    sub_q;
    logic                                    sub_len_q;
    logic [i2c_proto_pkg::LEN_W-1:0]         len_q;
    logic [i2c_proto_pkg::BYTE_W-1:0]        wdata_q;
    logic                                    accept;
    logic                                    last_byte;
    logic                                    fetch_cap;
    logic                                    rd_done;

    assign accept    = (state == i2c_proto_pkg::IDLE) && req_trans_i;
    assign last_byte = (byte_cnt == len_q - 1'b1);
    assign fetch_cap = (state == i2c_proto_pkg::WRITE_FETCH) && (step == 2'd2);
    assign rd_done   = (state == i2c_proto_pkg::READ_DATA) && sh.done;

    assign sh.ack_to_send = !last_byte;  // NACK ends the read

    // Shifter latches opcode and byte on go
    always_comb begin
        case (state)
            i2c_proto_pkg::START,
            i2c_proto_pkg::RESTART:   sh.op = i2c_proto_pkg::OP_START;
            i2c_proto_pkg::STOP:      sh.op = i2c_proto_pkg::OP_STOP;
            i2c_proto_pkg::READ_DATA: sh.op = i2c_proto_pkg::OP_RX_BYTE;
            default:                  sh.op = i2c_proto_pkg::OP_TX_BYTE;
        endcase
        case (state)
            i2c_proto_pkg::ADDR:      sh.tx_byte = {addr_q, 1'b0};  // W
            i2c_proto_pkg::READ_ADDR: sh.tx_byte = {addr_q, 1'b1};  // R
            i2c_proto_pkg::SUB_HI:
                sh.tx_byte = sub_q[i2c_proto_pkg::SUB_ADDR_W-1:i2c_proto_pkg::BYTE_W];
            i2c_proto_pkg::SUB_LO:    sh.tx_byte = sub_q[i2c_proto_pkg::BYTE_W-1:0];
            default:                  sh.tx_byte = wdata_q;
        endcase
    end

    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= i2c_proto_pkg::IDLE;
            step       <= '0;
            byte_cnt   <= '0;
            busy_o     <= 1'b0;
            nack_o     <= 1'b0;
            wr_req_o   <= 1'b0;
            rd_valid_o <= 1'b0;
            sh.go      <= 1'b0;
            bits.run   <= 1'b0;
        end else begin
            sh.go      <= 1'b0;
            wr_req_o   <= 1'b0;
            rd_valid_o <= 1'b0;
            case (state)
                i2c_proto_pkg::IDLE: begin
                    if (accept) begin
                        busy_o   <= 1'b1;
                        nack_o   <= 1'b0;  // Cleared by new request
                        bits.run <= 1'b1;  // SCL starts with a low phase
                        byte_cnt <= '0;
                        step     <= '0;
                        state    <= i2c_proto_pkg::START;
                    end
                end
                i2c_proto_pkg::WRITE_FETCH: begin
                    step     <= step + 1'b1;
                    wr_req_o <= (step == 2'd0);  // One-cycle request
                    if (step == 2'd2) begin  // Byte captured this cycle
                        step  <= '0;
                        state <= i2c_proto_pkg::WRITE_DATA;
                    end
                end
                default: begin
                    if (step == 2'd0) begin
                        sh.go <= 1'b1;  // Shifter idle here
                        step  <= 2'd1;
                    end else if (sh.done) begin
                        step <= '0;
                        case (state)
                            i2c_proto_pkg::START: state <= i2c_proto_pkg::ADDR;
                            i2c_proto_pkg::ADDR:
                                state <= sub_len_q ? i2c_proto_pkg::SUB_HI
                                                   : i2c_proto_pkg::SUB_LO;
                            i2c_proto_pkg::SUB_HI: state <= i2c_proto_pkg::SUB_LO;
                            i2c_proto_pkg::SUB_LO:
                                state <= rw_q ? i2c_proto_pkg::RESTART
                                              : i2c_proto_pkg::WRITE_FETCH;
                            i2c_proto_pkg::RESTART:   state <= i2c_proto_pkg::READ_ADDR;
                            i2c_proto_pkg::READ_ADDR: state <= i2c_proto_pkg::READ_DATA;
                            i2c_proto_pkg::WRITE_DATA: begin
                                byte_cnt <= byte_cnt + 1'b1;
                                state    <= last_byte ? i2c_proto_pkg::STOP
                                                      : i2c_proto_pkg::WRITE_FETCH;
                            end
                            i2c_proto_pkg::READ_DATA: begin
                                rd_valid_o <= 1'b1;
                                byte_cnt   <= byte_cnt + 1'b1;
                                state      <= last_byte ? i2c_proto_pkg::STOP
                                                        : i2c_proto_pkg::READ_DATA;
                            end
                            default: begin  // STOP finished
                                bits.run <= 1'b0;
                                busy_o   <= 1'b0;
                                state    <= i2c_proto_pkg::IDLE;
                            end
                        endcase
                        // Slave NACK on any sent byte aborts
                        if (sh.op == i2c_proto_pkg::OP_TX_BYTE && !sh.ack_seen) begin
                            nack_o <= 1'b1;
                            state  <= i2c_proto_pkg::STOP;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            addr_q    <= addr_i;
            rw_q      <= rw_i;
            sub_q     <= sub_addr_i;
            sub_len_q <= sub_len_i;
            len_q     <= byte_len_i;
        end
        if (fetch_cap)
            wdata_q <= data_write_i;  // Two cycles after wr_req_o
        if (rd_done)
            data_out_o <= sh.rx_byte;  // Same edge as rd_valid_o
    end

    // Each done answers exactly one go that is still waiting
    assert property (@(posedge i_clk) disable iff (!reset_n) sh.done |-> (step == 2'd1))
        else $error("shifter done without a pending operation");

endmodule

// ==== i2c_byte_shifter.sv ====
`timescale 1ns/100ps
module i2c_byte_shifter (
    input  logic          i_clk,
    input  logic          reset_n,
    input  logic          sda_line_i,  // SDA as seen on the bus
    i2c_bit_if.user       bits,
    i2c_shift_if.shifter  sh
);

    logic [i2c_timing_pkg::SYNC_STAGES-1:0] sda_sync;   // SDA synchronizer
    logic                                   sda_in;
    logic                                   active;     // Operation pending
    i2c_proto_pkg::shift_op_t               op_q;
    logic [3:0]                             bit_cnt;    // 0..7 data, 8 ACK slot
    logic [i2c_proto_pkg::BYTE_W-1:0]       sr;         // Shared TX and RX shifter
    logic                                   is_cond;
    logic                                   ack_slot;
    logic                                   last_slot;

    assign sda_in    = sda_sync[i2c_timing_pkg::SYNC_STAGES-1];
    assign is_cond   = (op_q == i2c_proto_pkg::OP_START) || (op_q == i2c_proto_pkg::OP_STOP);
    assign ack_slot  = (bit_cnt == 4'(i2c_proto_pkg::BYTE_W));
    assign last_slot = is_cond || ack_slot;  // START and STOP take one SCL period
    assign sh.rx_byte = sr;

    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            sda_sync    <= '1;
            active      <= 1'b0;
            op_q        <= i2c_proto_pkg::OP_START;
            bit_cnt     <= '0;
            sr          <= '0;
            sh.done     <= 1'b0;
            sh.ack_seen <= 1'b0;
            sh.sda_pull <= 1'b0;
        end else begin
            sda_sync <= {sda_sync[i2c_timing_pkg::SYNC_STAGES-2:0], sda_line_i};
            sh.done  <= 1'b0;
            if (sh.go && !active) begin
                active  <= 1'b1;
                op_q    <= sh.op;
                bit_cnt <= '0;
                sr      <= sh.tx_byte;
            end else if (active && bits.low_mid) begin  // SDA moves only here for data
                case (op_q)
                    i2c_proto_pkg::OP_START: sh.sda_pull <= 1'b0;  // SDA high first
                    i2c_proto_pkg::OP_STOP:  sh.sda_pull <= 1'b1;  // SDA low first
                    i2c_proto_pkg::OP_TX_BYTE: begin
                        if (ack_slot) begin
                            sh.sda_pull <= 1'b0;  // Let slave drive ACK
                        end else begin
                            sh.sda_pull <= !sr[i2c_proto_pkg::BYTE_W-1];  // MSB first
                            sr <= {sr[i2c_proto_pkg::BYTE_W-2:0], 1'b0};
                        end
                    end
                    default: sh.sda_pull <= ack_slot && sh.ack_to_send;  // Receive
                endcase
            end else if (active && bits.high_mid) begin
                if (op_q == i2c_proto_pkg::OP_START)
                    sh.sda_pull <= 1'b1;  // Falling SDA, START
                if (op_q == i2c_proto_pkg::OP_STOP)
                    sh.sda_pull <= 1'b0;  // Rising SDA, STOP
                if (op_q == i2c_proto_pkg::OP_TX_BYTE && ack_slot)
                    sh.ack_seen <= !sda_in;  // Low means ACK
                if (op_q == i2c_proto_pkg::OP_RX_BYTE && !ack_slot)
                    sr <= {sr[i2c_proto_pkg::BYTE_W-2:0], sda_in};
                if (last_slot) begin
                    active  <= 1'b0;
                    sh.done <= 1'b1;  // Cycle after last high_mid
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // Data stays stable while SCL is high, only START and STOP break that
    assert property (@(posedge i_clk) disable iff (!reset_n)
        (bits.scl_high && $changed(sh.sda_pull)) |-> is_cond)
        else $error("SDA changed while SCL high outside START/STOP");

endmodule

// ==== i2c_bit_timer.sv ====
`timescale 1ns/100ps
module i2c_bit_timer (
    input  logic      i_clk,
    input  logic      reset_n,
    input  logic      scl_line_i,  // SCL as seen on the bus
    i2c_bit_if.timer  bits
);

    logic [i2c_timing_pkg::SYNC_STAGES-1:0] scl_sync;   // SCL synchronizer
    logic [i2c_timing_pkg::HALF_CNT_W-1:0]  half_cnt;   // Cycles into half period
    logic                                   low_phase;  // We hold SCL low
    logic                                   at_mid;
    logic                                   at_end;

    assign bits.scl_high = scl_sync[i2c_timing_pkg::SYNC_STAGES-1];
    assign bits.scl_pull = bits.run && low_phase;  // Released whenever idle

    assign at_mid = (half_cnt == i2c_timing_pkg::MID_CYCLE);
    assign at_end = (half_cnt == i2c_timing_pkg::SCL_HALF_CYCLES - 1);

    assign bits.low_mid  = bits.run && low_phase && at_mid;
    // High strobe only counts once the line is really up
    assign bits.high_mid = bits.run && !low_phase && bits.scl_high && at_mid;

    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            scl_sync  <= '1;
            half_cnt  <= '0;
            low_phase <= 1'b1;
        end else begin
            scl_sync <= {scl_sync[i2c_timing_pkg::SYNC_STAGES-2:0], scl_line_i};
            if (!bits.run) begin
                half_cnt  <= '0;     // Restart so first phase is low
                low_phase <= 1'b1;
            end else if (!low_phase && !bits.scl_high) begin
                half_cnt <= half_cnt;  // Slave stretching holds SCL low after release
            end else if (at_end) begin
                half_cnt  <= '0;
                low_phase <= !low_phase;  // Toggle SCL
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // Low strobe lands while the bus line is really low
    assert property (@(posedge i_clk) disable iff (!reset_n)
        bits.low_mid |-> !bits.scl_high)
        else $error("low_mid fired while SCL line seen high");

endmodule

// ==== i2c_shift_if.sv ====
`timescale 1ns/100ps
interface i2c_shift_if;

    i2c_proto_pkg::shift_op_t           op;           // Operation for next go
    logic                               go;           // Start operation, one cycle
    logic [i2c_proto_pkg::BYTE_W-1:0]   tx_byte;      // Byte to send
    logic                               ack_to_send;  // 1 sends ACK, 0 sends NACK
    logic                               done;         // Operation finished, one cycle
    logic [i2c_proto_pkg::BYTE_W-1:0]   rx_byte;      // Byte received
    logic                               ack_seen;     // Slave answered ACK
    logic                               sda_pull;     // Pull SDA pad low

    modport ctrl (output op, go, tx_byte, ack_to_send,
                  input  done, rx_byte, ack_seen);
    modport shifter (input  op, go, tx_byte, ack_to_send,
                     output done, rx_byte, ack_seen, sda_pull);

endinterface

// ==== i2c_bit_if.sv ====
`timescale 1ns/100ps
interface i2c_bit_if;

    logic run;       // Clock generation enable
    logic low_mid;   // Middle of SCL low
    logic high_mid;  // Middle of SCL high, after SCL seen high
    logic scl_high;  // Synchronized SCL level
    logic scl_pull;  // Pull SCL pad low

    modport timer (input run, output low_mid, high_mid, scl_high, scl_pull);
    modport user  (input low_mid, high_mid, scl_high);
    modport ctrl  (output run);

endinterface

// ==== i2c_timing_pkg.sv ====
package i2c_timing_pkg;

    localparam int SCL_HALF_CYCLES = 125;  // 100 MHz in, 400 kHz SCL
    localparam int MID_CYCLE       = 62;   // Strobe point inside a half period
    localparam int SYNC_STAGES     = 2;    // Flops on SCL and SDA inputs

    // Half period counter width
    localparam int HALF_CNT_W = $clog2(SCL_HALF_CYCLES);

endpackage

// ==== i2c_proto_pkg.sv ====
package i2c_proto_pkg;

    localparam int BYTE_W     = 8;   // Data byte width
    localparam int SUB_ADDR_W = 16;  // Register address width, high byte optional
    localparam int LEN_W      = 8;   // Byte count, 1 to 255

    // Transaction controller states
    typedef enum logic [3:0] {
        IDLE,         // Waiting for host request
        START,        // START condition
        ADDR,         // Slave address with W
        SUB_HI,       // Sub-address high byte, 16-bit mode only
        SUB_LO,       // Sub-address low byte
        RESTART,      // Repeated START before a read
        READ_ADDR,    // Slave address with R
        WRITE_FETCH,  // Ask host for next byte
        WRITE_DATA,   // Send one data byte
        READ_DATA,    // Receive one data byte
        STOP          // STOP condition, then back to idle
    } txn_state_t;

    // Byte shifter operations
    typedef enum logic [1:0] {
        OP_START,     // SDA falls while SCL high
        OP_TX_BYTE,   // 8 bits out, ACK in
        OP_RX_BYTE,   // 8 bits in, ACK or NACK out
        OP_STOP       // SDA rises while SCL high
    } shift_op_t;

endpackage
